/* verilog/bank_dispatch_defs.svh */
`ifndef BANK_DISPATCH_DEFS_SVH
`define BANK_DISPATCH_DEFS_SVH

// Bank count and bank select width
`define DSP_NUM_BANKS 4
`define DSP_BANK_W $clog2(`DSP_NUM_BANKS)

// Word address, split into bank bits (low) and row bits (high)
`define DSP_ADDR_W 8
`define DSP_ROW_W (`DSP_ADDR_W - `DSP_BANK_W)

// Payload widths
`define DSP_DATA_W 32
`define DSP_TAG_W 4

// Words held by one bank
`define DSP_BANK_ROWS (1 << `DSP_ROW_W)

`endif

/* verilog/dispatch_pkg.sv */
`default_nettype none

`include "bank_dispatch_defs.svh"

package dispatch_pkg;

    // Bank number from the low address bits
    typedef logic [`DSP_BANK_W-1:0] bank_idx_t;

    // Row inside one bank
    typedef logic [`DSP_ROW_W-1:0] row_t;

    // Request toward one bank, 43 bits
    typedef struct packed {
        logic                   write;
        row_t                   row;
        logic [`DSP_DATA_W-1:0] data;
        logic [`DSP_TAG_W-1:0]  tag;
    } bank_req_t;

endpackage

`default_nettype wire

/* verilog/bank_pkg.sv */
`default_nettype none

`include "bank_dispatch_defs.svh"

package bank_pkg;

    // Response from one bank, 37 bits
    typedef struct packed {
        logic [`DSP_DATA_W-1:0] data;
        logic [`DSP_TAG_W-1:0]  tag;
        logic                   write;
    } bank_rsp_t;

endpackage

`default_nettype wire

/* verilog/skid_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

module skid_buffer #(
    parameter type payload_t = logic
) (
    input  wire      clk,
    input  wire      rst,
    input  wire      valid_in,
    input  wire      payload_t data_in,
    output logic     ready_in,
    output logic     valid_out,
    output payload_t data_out,
    input  wire      ready_out
);

    payload_t main_q;
    payload_t skid_q;
    logic     main_valid_q;
    logic     skid_valid_q;
    logic     main_free;

    // Upstream sees ready only while the skid slot is empty
    assign ready_in  = ~skid_valid_q;
    assign valid_out = main_valid_q;
    assign data_out  = main_q;
    assign main_free = ~main_valid_q | ready_out;

    always_ff @(posedge clk) begin
        if (rst) begin
            main_valid_q <= 1'b0;
            skid_valid_q <= 1'b0;
        end else if (skid_valid_q) begin
            // Drain the skid entry into the main slot
            if (ready_out) begin
                skid_valid_q <= 1'b0;
            end
        end else if (main_free) begin
            main_valid_q <= valid_in;
        end else if (valid_in) begin
            skid_valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (skid_valid_q) begin
            if (ready_out) begin
                main_q <= skid_q;
            end
        end else if (main_free) begin
            main_q <= data_in;
        end else begin
            skid_q <= data_in;
        end
    end

    a_hold_stable: assert property (@(posedge clk) disable iff (rst)
        valid_out && !ready_out |=> valid_out && $stable(data_out));

endmodule

`default_nettype wire

/* verilog/rr_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

`include "bank_dispatch_defs.svh"

module rr_arbiter #(
    parameter int num_reqs = `DSP_NUM_BANKS
) (
    input  wire                     clk,
    input  wire                     rst,
    input  wire [num_reqs-1:0]      requests,
    input  wire                     unlock,
    output logic                    grant_valid,
    output dispatch_pkg::bank_idx_t grant_index,
    output logic [num_reqs-1:0]     grant_onehot
);

    dispatch_pkg::bank_idx_t last_q;
    dispatch_pkg::bank_idx_t lock_idx_q;
    dispatch_pkg::bank_idx_t pick_idx;
    logic                    pick_valid;
    logic                    locked_q;

    // Search starts just past the last winner, nearest requester wins
    always_comb begin
        dispatch_pkg::bank_idx_t cand;
        pick_valid = 1'b0;
        pick_idx   = last_q;
        for (int i = num_reqs; i >= 1; i--) begin
            cand = dispatch_pkg::bank_idx_t'((int'(last_q) + i) % num_reqs);
            if (requests[cand]) begin
                pick_valid = 1'b1;
                pick_idx   = cand;
            end
        end
    end

    assign grant_index = locked_q ? lock_idx_q : pick_idx;
    assign grant_valid = locked_q ? requests[lock_idx_q] : pick_valid;

    always_comb begin
        grant_onehot = '0;
        if (grant_valid) begin
            grant_onehot[grant_index] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            locked_q   <= 1'b0;
            lock_idx_q <= '0;
            last_q     <= dispatch_pkg::bank_idx_t'(num_reqs - 1);
        end else if (unlock) begin
            locked_q <= 1'b0;
            last_q   <= grant_index;
        end else if (grant_valid) begin
            locked_q   <= 1'b1;
            lock_idx_q <= grant_index;
        end
    end

    a_grant_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(grant_onehot) && (grant_valid -> grant_onehot[grant_index]));

    // Held grant survives until its transfer
    a_grant_lock: assert property (@(posedge clk) disable iff (rst)
        grant_valid && !unlock |=> grant_valid && grant_index == $past(grant_index));

endmodule

`default_nettype wire

/* verilog/stream_demux.sv */
`timescale 1ns/100ps
`default_nettype none

`include "bank_dispatch_defs.svh"

module stream_demux #(
    parameter int num_outputs = `DSP_NUM_BANKS
) (
    input  wire                       clk,
    input  wire                       rst,
    input  wire dispatch_pkg::bank_idx_t sel,
    input  wire                       valid_in,
    input  wire dispatch_pkg::bank_req_t data_in,
    output logic                      ready_in,
    output logic [num_outputs-1:0]    valid_out,
    output dispatch_pkg::bank_req_t   data_out [num_outputs],
    input  wire [num_outputs-1:0]     ready_out
);

    logic [num_outputs-1:0] sel_onehot;
    logic [num_outputs-1:0] buf_valid;
    logic [num_outputs-1:0] buf_ready;

    always_comb begin
        sel_onehot      = '0;
        sel_onehot[sel] = 1'b1;
    end

    assign buf_valid = {num_outputs{valid_in}} & sel_onehot;
    assign ready_in  = buf_ready[sel];

    for (genvar i = 0; i < num_outputs; i++) begin : g_out
        skid_buffer #(
            .payload_t (dispatch_pkg::bank_req_t)
        ) u_out_buf (
            .clk       (clk),
            .rst       (rst),
            .valid_in  (buf_valid[i]),
            .data_in   (data_in),
            .ready_in  (buf_ready[i]),
            .valid_out (valid_out[i]),
            .data_out  (data_out[i]),
            .ready_out (ready_out[i])
        );
    end

    a_one_target: assert property (@(posedge clk) disable iff (rst)
        $onehot0(buf_valid) && (valid_in -> buf_valid[sel]));

endmodule

`default_nettype wire

/* verilog/stream_mux.sv */
`timescale 1ns/100ps
`default_nettype none

`include "bank_dispatch_defs.svh"

module stream_mux #(
    parameter int num_inputs = `DSP_NUM_BANKS
) (
    input  wire                    clk,
    input  wire                    rst,
    input  wire [num_inputs-1:0]   valid_in,
    input  wire bank_pkg::bank_rsp_t data_in [num_inputs],
    output logic [num_inputs-1:0]  ready_in,
    output logic                   valid_out,
    output bank_pkg::bank_rsp_t    data_out,
    input  wire                    ready_out
);

    logic                    grant_valid;
    dispatch_pkg::bank_idx_t grant_index;
    logic [num_inputs-1:0]   grant_onehot;
    logic                    buf_ready;
    logic                    buf_fire;

    // Grant releases on the transfer into the output buffer
    assign buf_fire = grant_valid & buf_ready;
    assign ready_in = grant_onehot & {num_inputs{buf_ready}};

    rr_arbiter #(
        .num_reqs (num_inputs)
    ) u_arbiter (
        .clk          (clk),
        .rst          (rst),
        .requests     (valid_in),
        .unlock       (buf_fire),
        .grant_valid  (grant_valid),
        .grant_index  (grant_index),
        .grant_onehot (grant_onehot)
    );

    skid_buffer #(
        .payload_t (bank_pkg::bank_rsp_t)
    ) u_out_buf (
        .clk       (clk),
        .rst       (rst),
        .valid_in  (grant_valid),
        .data_in   (data_in[grant_index]),
        .ready_in  (buf_ready),
        .valid_out (valid_out),
        .data_out  (data_out),
        .ready_out (ready_out)
    );

endmodule

`default_nettype wire

/* verilog/mem_bank.sv */
`timescale 1ns/100ps
`default_nettype none

`include "bank_dispatch_defs.svh"

module mem_bank #(
    parameter int rows = `DSP_BANK_ROWS
) (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       req_valid,
    input  wire dispatch_pkg::bank_req_t req,
    output logic                      req_ready,
    output logic                      rsp_valid,
    output bank_pkg::bank_rsp_t       rsp,
    input  wire                       rsp_ready
);

    logic [`DSP_DATA_W-1:0] mem [rows];
    bank_pkg::bank_rsp_t    rsp_q;
    logic                   rsp_valid_q;
    logic                   req_fire;

    // Response slot frees up in the same cycle it is read out
    assign req_ready = ~rsp_valid_q | rsp_ready;
    assign req_fire  = req_valid & req_ready;
    assign rsp_valid = rsp_valid_q;
    assign rsp       = rsp_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_valid_q <= 1'b0;
        end else if (req_fire) begin
            rsp_valid_q <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            if (req.write) begin
                mem[req.row] <= req.data;
            end
            // Writes echo their own data
            rsp_q.data  <= req.write ? req.data : mem[req.row];
            rsp_q.tag   <= req.tag;
            rsp_q.write <= req.write;
        end
    end

endmodule

`default_nettype wire

/* verilog/bank_dispatch.sv */
`timescale 1ns/100ps
`default_nettype none

`include "bank_dispatch_defs.svh"

module bank_dispatch (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   req_valid,
    input  wire                   req_write,
    input  wire [`DSP_ADDR_W-1:0] req_addr,
    input  wire [`DSP_DATA_W-1:0] req_data,
    input  wire [`DSP_TAG_W-1:0]  req_tag,
    output logic                  req_ready,
    output logic                  rsp_valid,
    output logic [`DSP_DATA_W-1:0] rsp_data,
    output logic [`DSP_TAG_W-1:0] rsp_tag,
    output logic                  rsp_write,
    input  wire                   rsp_ready
);

    logic                    slot_valid_q;
    dispatch_pkg::bank_idx_t slot_sel_q;
    dispatch_pkg::bank_req_t slot_req_q;
    logic                    dmx_ready;

    logic [`DSP_NUM_BANKS-1:0] bank_req_valid;
    dispatch_pkg::bank_req_t   bank_req [`DSP_NUM_BANKS];
    logic [`DSP_NUM_BANKS-1:0] bank_req_ready;
    logic [`DSP_NUM_BANKS-1:0] bank_rsp_valid;
    bank_pkg::bank_rsp_t       bank_rsp [`DSP_NUM_BANKS];
    logic [`DSP_NUM_BANKS-1:0] bank_rsp_ready;
    bank_pkg::bank_rsp_t       mux_rsp;

    // Decode slot, one request deep
    assign req_ready = ~slot_valid_q | dmx_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            slot_valid_q <= 1'b0;
        end else if (req_valid && req_ready) begin
            slot_valid_q <= 1'b1;
        end else if (dmx_ready) begin
            slot_valid_q <= 1'b0;
        end
    end

    // Bank from the low address bits, row from the rest
    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            slot_sel_q       <= req_addr[`DSP_BANK_W-1:0];
            slot_req_q.write <= req_write;
            slot_req_q.row   <= req_addr[`DSP_ADDR_W-1:`DSP_BANK_W];
            slot_req_q.data  <= req_data;
            slot_req_q.tag   <= req_tag;
        end
    end

    stream_demux u_demux (
        .clk       (clk),
        .rst       (rst),
        .sel       (slot_sel_q),
        .valid_in  (slot_valid_q),
        .data_in   (slot_req_q),
        .ready_in  (dmx_ready),
        .valid_out (bank_req_valid),
        .data_out  (bank_req),
        .ready_out (bank_req_ready)
    );

    for (genvar b = 0; b < `DSP_NUM_BANKS; b++) begin : g_bank
        mem_bank u_bank (
            .clk       (clk),
            .rst       (rst),
            .req_valid (bank_req_valid[b]),
            .req       (bank_req[b]),
            .req_ready (bank_req_ready[b]),
            .rsp_valid (bank_rsp_valid[b]),
            .rsp       (bank_rsp[b]),
            .rsp_ready (bank_rsp_ready[b])
        );
    end

    stream_mux u_mux (
        .clk       (clk),
        .rst       (rst),
        .valid_in  (bank_rsp_valid),
        .data_in   (bank_rsp),
        .ready_in  (bank_rsp_ready),
        .valid_out (rsp_valid),
        .data_out  (mux_rsp),
        .ready_out (rsp_ready)
    );

    assign rsp_data  = mux_rsp.data;
    assign rsp_tag   = mux_rsp.tag;
    assign rsp_write = mux_rsp.write;

endmodule

`default_nettype wire

/* tb/clock_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module clock_gen #(
    parameter int half_period  = 20,
    parameter int reset_cycles = 4
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    // Reset drops on a falling edge, clear of the sampling edge
    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

/* tb/bank_checker.sv */
`timescale 1ns/100ps
`default_nettype none

`include "bank_dispatch_defs.svh"

module bank_checker #(
    parameter int num_tags  = 1 << `DSP_TAG_W,
    parameter int age_limit = 2000
) (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   rsp_valid,
    input  wire                   rsp_ready,
    input  wire [`DSP_DATA_W-1:0] rsp_data,
    input  wire [`DSP_TAG_W-1:0]  rsp_tag,
    input  wire                   rsp_write,
    input  wire [`DSP_DATA_W-1:0] exp_data [num_tags],
    input  wire                   exp_write [num_tags],
    input  var int                issue_count [num_tags],
    output int                    done_count [num_tags],
    output int                    arrival [num_tags],
    output int                    value_errors,
    output int                    tag_errors,
    output int                    late_errors
);

    int age [num_tags];
    int rsp_total;

    always @(posedge clk) begin
        if (rst) begin
            rsp_total    = 0;
            value_errors = 0;
            tag_errors   = 0;
            late_errors  = 0;
            for (int t = 0; t < num_tags; t++) begin
                done_count[t] = 0;
                arrival[t]    = -1;
                age[t]        = 0;
            end
        end else begin
            // Age of every outstanding tag
            for (int t = 0; t < num_tags; t++) begin
                if (issue_count[t] != done_count[t]) begin
                    age[t]++;
                    if (age[t] == age_limit) begin
                        $display("Tag %0d got no response within %0d cycles", t, age_limit);
                        late_errors++;
                    end
                end else begin
                    age[t] = 0;
                end
            end

            if (rsp_valid && rsp_ready) begin
                if (issue_count[rsp_tag] == done_count[rsp_tag]) begin
                    $display("A response with tag %0d arrived but no such request was outstanding",
                             rsp_tag);
                    tag_errors++;
                end else begin
                    if (rsp_data !== exp_data[rsp_tag] || rsp_write !== exp_write[rsp_tag]) begin
                        $display("Error at %0t: tag %0d gave data %h write %b, expected %h write %b",
                                 $time, rsp_tag, rsp_data, rsp_write,
                                 exp_data[rsp_tag], exp_write[rsp_tag]);
                        value_errors++;
                    end
                    done_count[rsp_tag]++;
                    arrival[rsp_tag] = rsp_total;
                    rsp_total++;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* tb/bank_dispatch_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "bank_dispatch_defs.svh"

module bank_dispatch_tb;

    localparam int num_tags    = 1 << `DSP_TAG_W;
    localparam int num_words   = 1 << `DSP_ADDR_W;
    localparam int wait_limit  = 2000;
    localparam int drain_limit = 5000;

    typedef logic [`DSP_ADDR_W-1:0] addr_t;
    typedef logic [`DSP_DATA_W-1:0] data_t;
    typedef logic [`DSP_TAG_W-1:0]  tag_t;

    wire   clk;
    wire   rst;
    logic  req_valid;
    logic  req_write;
    addr_t req_addr;
    data_t req_data;
    tag_t  req_tag;
    wire   req_ready;
    wire   rsp_valid;
    data_t rsp_data;
    tag_t  rsp_tag;
    wire   rsp_write;
    logic  rsp_ready  = 1'b1;
    int    stall_left = 0;
    logic  stall_mode;

    data_t ref_mem [num_words];
    data_t exp_data [num_tags];
    logic  exp_write [num_tags];
    int    issue_count [num_tags];
    int    done_count [num_tags];
    int    arrival [num_tags];
    int    value_errors;
    int    tag_errors;
    int    late_errors;
    int    tb_errors;
    logic  aborted;
    tag_t  next_tag;

    clock_gen u_clock_gen (
        .clk (clk),
        .rst (rst)
    );

    bank_dispatch UUT (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req_write (req_write),
        .req_addr  (req_addr),
        .req_data  (req_data),
        .req_tag   (req_tag),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data),
        .rsp_tag   (rsp_tag),
        .rsp_write (rsp_write),
        .rsp_ready (rsp_ready)
    );

    bank_checker u_checker (
        .clk          (clk),
        .rst          (rst),
        .rsp_valid    (rsp_valid),
        .rsp_ready    (rsp_ready),
        .rsp_data     (rsp_data),
        .rsp_tag      (rsp_tag),
        .rsp_write    (rsp_write),
        .exp_data     (exp_data),
        .exp_write    (exp_write),
        .issue_count  (issue_count),
        .done_count   (done_count),
        .arrival      (arrival),
        .value_errors (value_errors),
        .tag_errors   (tag_errors),
        .late_errors  (late_errors)
    );

    // Long low stretches and short high bursts
    always @(negedge clk) begin
        if (!stall_mode) begin
            rsp_ready <= 1'b1;
        end else if (stall_left > 0) begin
            stall_left <= stall_left - 1;
        end else begin
            rsp_ready  <= ~rsp_ready;
            stall_left <= rsp_ready ? $urandom_range(10, 40) : $urandom_range(1, 6);
        end
    end

    // Expected response and the model update of a write
    function automatic data_t ref_response(input logic write, input addr_t addr, input data_t data);
        data_t result;
        result = write ? data : ref_mem[addr];
        if (write) begin
            ref_mem[addr] = data;
        end
        return result;
    endfunction

    function automatic data_t fill_word(input addr_t addr);
        return {~addr, addr ^ 8'h5a, addr, addr + 8'h3c};
    endfunction

    function automatic logic all_done();
        for (int t = 0; t < num_tags; t++) begin
            if (issue_count[t] != done_count[t]) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic check_reset();
        int   edges;
        logic in_reset;
        edges = 0;
        // Rst is stable on rising edges and outputs on falling edges
        do begin
            @(posedge clk);
            in_reset = (rst === 1'b1);
            edges++;
            @(negedge clk);
            if (rsp_valid !== 1'b0 || req_ready !== 1'b1) begin
                $display("Error at %0t: rsp_valid %b req_ready %b during or after reset",
                         $time, rsp_valid, req_ready);
                tb_errors++;
            end
            if (edges > 20) begin
                $display("Reset never ended");
                aborted = 1'b1;
            end
        end while (in_reset && !aborted);
    endtask

    task automatic send(input logic write, input addr_t addr, input data_t data);
        tag_t tag;
        int   waited;
        tag    = next_tag;
        waited = 0;
        while (!aborted && issue_count[tag] != done_count[tag]) begin
            @(negedge clk);
            waited++;
            if (waited > wait_limit) begin
                $display("Timed out waiting for the response to tag %0d", tag);
                aborted = 1'b1;
            end
        end
        if (aborted) begin
            return;
        end
        req_valid = 1'b1;
        req_write = write;
        req_addr  = addr;
        req_data  = data;
        req_tag   = tag;
        waited    = 0;
        while (!aborted && req_ready !== 1'b1) begin
            @(negedge clk);
            waited++;
            if (waited > wait_limit) begin
                $display("Timed out waiting for req_ready");
                aborted = 1'b1;
            end
        end
        if (!aborted) begin
            // Transfer on the coming rising edge
            exp_data[tag]  = ref_response(write, addr, data);
            exp_write[tag] = write;
            issue_count[tag]++;
            next_tag++;
            @(negedge clk);
        end
        req_valid = 1'b0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (!aborted && !all_done()) begin
            @(negedge clk);
            waited++;
            if (waited > drain_limit) begin
                $display("Timed out waiting for the outstanding responses");
                aborted = 1'b1;
            end
        end
    endtask

    initial begin
        tag_t order_tags [$];
        int   last_arrival;
        req_valid  = 1'b0;
        req_write  = 1'b0;
        req_addr   = '0;
        req_data   = '0;
        req_tag    = '0;
        stall_mode = 1'b0;
        aborted    = 1'b0;
        tb_errors  = 0;
        next_tag   = '0;
        for (int t = 0; t < num_tags; t++) begin
            exp_data[t]    = '0;
            exp_write[t]   = 1'b0;
            issue_count[t] = 0;
        end
        for (int a = 0; a < num_words; a++) begin
            ref_mem[a] = 'x;
        end
        void'($urandom(32'h42c0));
        check_reset();

        // Every word written and then read back
        for (int a = 0; a < num_words; a++) begin
            send(1'b1, addr_t'(a), fill_word(addr_t'(a)));
        end
        for (int a = 0; a < num_words; a++) begin
            send(1'b0, addr_t'(a), '0);
        end
        drain();

        for (int i = 0; i < 300; i++) begin
            send(1'($urandom), addr_t'($urandom), $urandom);
        end
        drain();

        // Back-to-back requests to bank 2 only
        for (int i = 0; i < 12; i++) begin
            order_tags.push_back(next_tag);
            send(i % 2 == 0, addr_t'((i / 2) * 4 + 2), $urandom);
        end
        drain();
        last_arrival = -1;
        foreach (order_tags[i]) begin
            if (!aborted && arrival[order_tags[i]] <= last_arrival) begin
                $display("Error at %0t: bank 2 response for tag %0d out of request order",
                         $time, order_tags[i]);
                tb_errors++;
            end
            last_arrival = arrival[order_tags[i]];
        end

        stall_mode = 1'b1;
        for (int i = 0; i < 200; i++) begin
            send(1'($urandom), addr_t'($urandom), $urandom);
        end
        drain();
        stall_mode = 1'b0;

        // Spread over all banks with rsp_ready high
        for (int i = 0; i < 64; i++) begin
            send(1'b0, addr_t'(i), '0);
        end
        drain();

        $display("Error counts: value %0d, tag %0d, late %0d, testbench %0d",
                 value_errors, tag_errors, late_errors, tb_errors);
        if (aborted || value_errors + tag_errors + late_errors + tb_errors != 0) begin
            $display("Something failed");
        end else begin
            $display("Everything OK");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* bank_dispatch.f */
+incdir+verilog
verilog/dispatch_pkg.sv
verilog/bank_pkg.sv
verilog/skid_buffer.sv
verilog/rr_arbiter.sv
verilog/stream_demux.sv
verilog/stream_mux.sv
verilog/mem_bank.sv
verilog/bank_dispatch.sv
tb/clock_gen.sv
tb/bank_checker.sv
tb/bank_dispatch_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the bank_dispatch testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f bank_dispatch.f --top-module bank_dispatch_tb \
    -Mdir obj_dir -o sim_bank_dispatch

./obj_dir/sim_bank_dispatch | tee sim.log

if grep -q "Everything OK" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
